/* files.f */
source/periph_pkg.sv
source/apb_decoder.sv
source/apb_led.sv
source/keypad_scan.sv
source/key_debounce.sv
source/apb_key.sv
source/apb_timer.sv
source/apb_periph_top.sv
testbench/tb_clock.sv
testbench/apb_periph_props.sv
testbench/tb_top.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_top
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* testbench/tb_top.sv */
`timescale 1ns/100ps

module tb_top;

    // All tests together take well under 1000 cycles
    localparam int TIMEOUT_CYCLES = 4000;
    // Worst case scan phase plus debounce plus margin
    localparam int KEY_WAIT = 4 * periph_pkg::SCAN_TICKS + periph_pkg::DEBOUNCE_TICKS + 16;

    localparam periph_pkg::apb_addr_t LED_ADDR    = {periph_pkg::SLOT_LED, 12'h000};
    localparam periph_pkg::apb_addr_t KEY_DATA_A  = {periph_pkg::SLOT_KEY, 12'h000};
    localparam periph_pkg::apb_addr_t KEY_INTEN_A = {periph_pkg::SLOT_KEY, 12'h004};
    localparam periph_pkg::apb_addr_t KEY_STAT_A  = {periph_pkg::SLOT_KEY, 12'h008};
    localparam periph_pkg::apb_addr_t TMR_CTRL_A  = {periph_pkg::SLOT_TIMER, 12'h000};
    localparam periph_pkg::apb_addr_t TMR_VALUE_A = {periph_pkg::SLOT_TIMER, 12'h004};
    localparam periph_pkg::apb_addr_t TMR_RELOAD_A = {periph_pkg::SLOT_TIMER, 12'h008};
    localparam periph_pkg::apb_addr_t TMR_STAT_A  = {periph_pkg::SLOT_TIMER, 12'h00C};

    logic                 clk;
    logic                 RSTn;
    periph_pkg::apb_req_t apb_req;
    periph_pkg::apb_rsp_t apb_rsp;
    periph_pkg::col_t     col;
    periph_pkg::row_t     row;
    periph_pkg::led_t     led;
    periph_pkg::irq_t     irq;
    periph_pkg::keypad_t  pressed;    // Keys held down by the tests
    logic [31:0]          rng;
    int unsigned          cycles = 0;
    int unsigned          errors = 0;
    int unsigned          checks = 0;

    tb_clock clock_i (.clk(clk), .RSTn(RSTn));

    apb_periph_top dut_i (
        .clk     (clk),
        .RSTn    (RSTn),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .col     (col),
        .row     (row),
        .led     (led),
        .irq     (irq)
    );

    bind apb_periph_top apb_periph_props props_i (
        .clk(clk), .RSTn(RSTn), .apb_rsp(apb_rsp), .row(row), .irq(irq)
    );

    // Keypad matrix, a held key shorts its column to a low row
    always_comb begin
        col = '1;
        for (int r = 0; r < periph_pkg::KEYPAD_ROWS; r++) begin
            for (int c = 0; c < periph_pkg::KEYPAD_COLS; c++) begin
                if (pressed[r * periph_pkg::KEYPAD_COLS + c] && !row[r]) col[c] = 1'b0;
            end
        end
    end

    always @(posedge clk) cycles <= cycles + 1;

    initial begin
        wait (cycles >= TIMEOUT_CYCLES);
        $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    //--------------------------------------------------
    // Helpers
    //--------------------------------------------------
    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic compare(input logic [31:0] expected, input logic [31:0] actual,
                           input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t ns: %s expected %h, got %h", $time, what, expected, actual);
        end
    endtask

    task automatic apb_write(input periph_pkg::apb_addr_t addr,
                             input periph_pkg::apb_data_t data);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(posedge clk);    // Write lands on this edge
        apb_req <= '0;
    endtask

    task automatic apb_read(input periph_pkg::apb_addr_t addr,
                            output periph_pkg::apb_data_t data);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        data = apb_rsp.prdata;    // Middle of the access cycle
        @(posedge clk);
        apb_req <= '0;
    endtask

    // Poll KEY_DATA until a bit reaches the level or the wait runs out
    task automatic wait_key_data(input int idx, input logic level);
        int unsigned           start;
        periph_pkg::apb_data_t data;
        start = cycles;
        apb_read(KEY_DATA_A, data);
        while (data[idx] !== level && (cycles - start) < KEY_WAIT) begin
            apb_read(KEY_DATA_A, data);
        end
        compare(32'(level), 32'(data[idx]), $sformatf("KEY_DATA bit %0d", idx));
    endtask

    //--------------------------------------------------
    // Directed tests
    //--------------------------------------------------
    task automatic led_writes();
        periph_pkg::apb_data_t wdata;
        periph_pkg::apb_data_t rdata;
        for (int i = 0; i < 6; i++) begin
            rng = next_random(rng);
            wdata = rng;
            apb_write(LED_ADDR, wdata);
            @(negedge clk);
            compare({24'h0, wdata[7:0]}, {24'h0, led}, "led pins");
            apb_read(LED_ADDR, rdata);
            compare({24'h0, wdata[7:0]}, rdata, "LED read-back");
        end
    endtask

    task automatic decode_holes();
        periph_pkg::apb_data_t rdata;
        apb_read(16'h0000, rdata);
        compare(32'h0, rdata, "slot 0 read");
        apb_read(16'h5000, rdata);
        compare(32'h0, rdata, "slot 5 read");
        apb_write(16'h0000, 32'hFFFF_FFFF);
        apb_write(16'h0004, 32'hFFFF_FFFF);
        apb_write(16'h5008, 32'hFFFF_FFFF);
        apb_read(LED_ADDR, rdata);
        // Last byte written by the LED test
        compare({24'h0, rng[7:0]}, rdata, "LED after unmapped writes");
        apb_read(KEY_INTEN_A, rdata);
        compare(32'h0, rdata, "KEY_INTEN after unmapped writes");
        apb_read(TMR_RELOAD_A, rdata);
        compare(32'h0, rdata, "TMR_RELOAD after unmapped writes");
        apb_read(TMR_CTRL_A, rdata);
        compare(32'h0, rdata, "TMR_CTRL after unmapped writes");
    endtask

    task automatic keypad_press();
        @(posedge clk);
        pressed[2] <= 1'b1;
        wait_key_data(2, 1'b1);
        @(posedge clk);
        pressed[2] <= 1'b0;
        wait_key_data(2, 1'b0);
        @(negedge clk);
        compare(32'h0, 32'(irq.key_int), "key irq with enables off");
    endtask

    task automatic key_interrupts();
        periph_pkg::apb_data_t rdata;
        apb_write(KEY_STAT_A, 32'hF);    // Drop the edge left by key 2
        apb_write(KEY_INTEN_A, 32'h2);
        @(posedge clk);
        pressed[1] <= 1'b1;
        wait_key_data(1, 1'b1);
        @(posedge clk);
        pressed[3] <= 1'b1;
        wait_key_data(3, 1'b1);
        apb_read(KEY_STAT_A, rdata);
        compare(32'hA, rdata, "KEY_INTSTAT after keys 1 and 3");
        @(negedge clk);
        compare(32'h2, 32'(irq.key_int), "key irq, only key 1 enabled");
        apb_write(KEY_STAT_A, 32'h2);
        apb_read(KEY_STAT_A, rdata);
        compare(32'h8, rdata, "KEY_INTSTAT after clearing bit 1");
        @(negedge clk);
        compare(32'h0, 32'(irq.key_int), "key irq after clear");
        @(posedge clk);
        pressed <= '0;
        wait_key_data(1, 1'b0);
        wait_key_data(3, 1'b0);
    endtask

    task automatic timer_reload();
        periph_pkg::apb_data_t rdata;
        apb_write(TMR_RELOAD_A, 32'd5);
        apb_write(TMR_VALUE_A, 32'd5);
        apb_write(TMR_CTRL_A, 32'h3);
        // Counts 5 down to 0 over five edges, reload on the sixth
        repeat (5) @(posedge clk);
        @(negedge clk);
        compare(32'h0, 32'(irq.timer_int), "timer irq one cycle before reload");
        @(posedge clk);
        @(negedge clk);
        compare(32'h1, 32'(irq.timer_int), "timer irq six cycles after enable");
        apb_read(TMR_VALUE_A, rdata);
        compare(32'h1, 32'(rdata <= 32'd5), "TMR_VALUE within reload range");
        apb_write(TMR_CTRL_A, 32'h2);    // Stop counting, irq stays enabled
        apb_write(TMR_STAT_A, 32'h1);
        @(negedge clk);
        compare(32'h0, 32'(irq.timer_int), "timer irq after status clear");
        apb_read(TMR_STAT_A, rdata);
        compare(32'h0, rdata, "TMR_INTSTAT after clear");
    endtask

    //--------------------------------------------------
    // Main sequence
    //--------------------------------------------------
    initial begin
        apb_req = '0;
        pressed = '0;
        rng = 32'he5c9_f12b;
        wait (RSTn === 1'b1);
        led_writes();
        decode_holes();
        keypad_press();
        key_interrupts();
        timer_reload();
        repeat (2) @(posedge clk);
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut_i.props_i.fail_cnt);
        if (errors == 0 && dut_i.props_i.fail_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* testbench/apb_periph_props.sv */
`timescale 1ns/100ps

module apb_periph_props (
    input logic                 clk,
    input logic                 RSTn,
    input periph_pkg::apb_rsp_t apb_rsp,
    input periph_pkg::row_t     row,
    input periph_pkg::irq_t     irq
);

    int unsigned fail_cnt = 0;    // Read by the testbench summary

    // Keypad drives exactly one row low at any time
    row_one_low: assert property (@(posedge clk) $onehot(~row))
        else begin
            $error("row pins %b do not have exactly one low bit", row);
            fail_cnt++;
        end

    // No wait states, no slave errors
    apb_rsp_fixed: assert property (@(posedge clk) apb_rsp.pready && !apb_rsp.pslverr)
        else begin
            $error("pready %b pslverr %b", apb_rsp.pready, apb_rsp.pslverr);
            fail_cnt++;
        end

    irq_quiet_in_reset: assert property (@(posedge clk) !RSTn |-> (irq == '0))
        else begin
            $error("irq %b active while reset is low", irq);
            fail_cnt++;
        end

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic RSTn
);

    localparam int HALF_PERIOD = 4;    // 8 ns clock
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        RSTn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        RSTn <= 1'b1;
    end

endmodule

/* source/apb_periph_top.sv */
`timescale 1ns/100ps

module apb_periph_top (
    input  logic                 clk,
    input  logic                 RSTn,
    input  periph_pkg::apb_req_t apb_req,
    output periph_pkg::apb_rsp_t apb_rsp,
    input  periph_pkg::col_t     col,
    output periph_pkg::row_t     row,
    output periph_pkg::led_t     led,
    output periph_pkg::irq_t     irq
);

    logic sel_led;
    logic sel_key;
    logic sel_timer;

    periph_pkg::apb_data_t rdata_led;
    periph_pkg::apb_data_t rdata_key;
    periph_pkg::apb_data_t rdata_timer;

    periph_pkg::keypad_t  keypad_level;    // Raw scanned matrix
    periph_pkg::key_vec_t key_clean;       // Row 0 after debounce

    //--------------------------------------------------
    // APB decode
    //--------------------------------------------------
    apb_decoder u_decoder (
        .apb_req     (apb_req),
        .sel_led     (sel_led),
        .sel_key     (sel_key),
        .sel_timer   (sel_timer),
        .rdata_led   (rdata_led),
        .rdata_key   (rdata_key),
        .rdata_timer (rdata_timer),
        .apb_rsp     (apb_rsp)
    );

    // Slot 1
    apb_led u_led (
        .clk     (clk),
        .RSTn    (RSTn),
        .apb_req (apb_req),
        .sel     (sel_led),
        .rdata   (rdata_led),
        .led     (led)
    );

    //--------------------------------------------------
    // Keypad path
    //--------------------------------------------------
    keypad_scan u_scan (
        .clk  (clk),
        .RSTn (RSTn),
        .col  (col),
        .row  (row),
        .keys (keypad_level)
    );

    for (genvar i = 0; i < periph_pkg::KEY_N; i++) begin : g_debounce
        key_debounce u_debounce (
            .clk     (clk),
            .RSTn    (RSTn),
            .key_in  (keypad_level[i]),
            .key_out (key_clean[i])
        );
    end

    // Slot 2
    apb_key u_key (
        .clk     (clk),
        .RSTn    (RSTn),
        .apb_req (apb_req),
        .sel     (sel_key),
        .keys    (key_clean),
        .rdata   (rdata_key),
        .key_int (irq.key_int)
    );

    // Slot 3
    apb_timer u_timer (
        .clk       (clk),
        .RSTn      (RSTn),
        .apb_req   (apb_req),
        .sel       (sel_timer),
        .rdata     (rdata_timer),
        .timer_int (irq.timer_int)
    );

endmodule

/* source/apb_timer.sv */
`timescale 1ns/100ps

module apb_timer (
    input  logic                  clk,
    input  logic                  RSTn,
    input  periph_pkg::apb_req_t  apb_req,
    input  logic                  sel,
    output periph_pkg::apb_data_t rdata,
    output logic                  timer_int
);

    periph_pkg::reg_ofs_t ofs;
    logic                 wr_en;
    logic                 wr_ctrl;
    logic                 wr_value;
    logic                 wr_reload;
    logic                 wr_stat;

    logic [1:0]            ctrl;      // [0] count enable, [1] irq enable
    periph_pkg::apb_data_t value;
    periph_pkg::apb_data_t reload;
    logic                  status;
    logic                  wrap;

    assign ofs       = apb_req.paddr[11:0];
    assign wr_en     = sel && apb_req.penable && apb_req.pwrite;
    assign wr_ctrl   = wr_en && (ofs == periph_pkg::TMR_CTRL);
    assign wr_value  = wr_en && (ofs == periph_pkg::TMR_VALUE);
    assign wr_reload = wr_en && (ofs == periph_pkg::TMR_RELOAD);
    assign wr_stat   = wr_en && (ofs == periph_pkg::TMR_INTSTAT);

    // Counter sits at zero this cycle
    assign wrap = ctrl[0] && (value == '0);

    //--------------------------------------------------
    // Control and counter
    //--------------------------------------------------
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            ctrl   <= '0;
            reload <= '0;
            value  <= '0;
        end else begin
            if (wr_ctrl) begin
                ctrl <= apb_req.pwdata[1:0];
            end
            if (wr_reload) begin
                reload <= apb_req.pwdata;
            end
            if (wr_value) begin
                value <= apb_req.pwdata;    // Direct load beats counting
            end else if (wrap) begin
                value <= reload;
            end else if (ctrl[0]) begin
                value <= value - 1'b1;
            end
        end
    end

    // Sticky flag, write one to clear
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            status <= 1'b0;
        end else if (wrap) begin
            status <= 1'b1;
        end else if (wr_stat && apb_req.pwdata[0]) begin
            status <= 1'b0;
        end
    end

    always_comb begin
        case (ofs)
            periph_pkg::TMR_CTRL:    rdata = periph_pkg::apb_data_t'(ctrl);
            periph_pkg::TMR_VALUE:   rdata = value;
            periph_pkg::TMR_RELOAD:  rdata = reload;
            periph_pkg::TMR_INTSTAT: rdata = periph_pkg::apb_data_t'(status);
            default:                 rdata = '0;
        endcase
    end

    assign timer_int = status && ctrl[1];

endmodule

/* source/apb_key.sv */
`timescale 1ns/100ps

module apb_key (
    input  logic                   clk,
    input  logic                   RSTn,
    input  periph_pkg::apb_req_t   apb_req,
    input  logic                   sel,
    input  periph_pkg::key_vec_t   keys,
    output periph_pkg::apb_data_t  rdata,
    output periph_pkg::key_vec_t   key_int
);

    periph_pkg::reg_ofs_t ofs;
    logic                 wr_en;
    logic                 clr_en;

    periph_pkg::key_vec_t keys_q;
    periph_pkg::key_vec_t rise;
    periph_pkg::key_vec_t inten;
    periph_pkg::key_vec_t status;
    periph_pkg::key_vec_t clr_mask;

    assign ofs      = apb_req.paddr[11:0];
    assign wr_en    = sel && apb_req.penable && apb_req.pwrite;
    assign clr_en   = wr_en && (ofs == periph_pkg::KEY_INTSTAT);
    assign clr_mask = clr_en ? apb_req.pwdata[periph_pkg::KEY_N-1:0] : '0;

    // Rising edges of the debounced keys
    assign rise = keys & ~keys_q;

    //--------------------------------------------------
    // Registers
    //--------------------------------------------------
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            keys_q <= '0;
            inten  <= '0;
            status <= '0;
        end else begin
            keys_q <= keys;
            if (wr_en && (ofs == periph_pkg::KEY_INTEN)) begin
                inten <= apb_req.pwdata[periph_pkg::KEY_N-1:0];
            end
            status <= (status & ~clr_mask) | rise;    // New edge wins over clear
        end
    end

    always_comb begin
        case (ofs)
            periph_pkg::KEY_DATA:    rdata = periph_pkg::apb_data_t'(keys);
            periph_pkg::KEY_INTEN:   rdata = periph_pkg::apb_data_t'(inten);
            periph_pkg::KEY_INTSTAT: rdata = periph_pkg::apb_data_t'(status);
            default:                 rdata = '0;
        endcase
    end

    assign key_int = status & inten;

endmodule

/* source/key_debounce.sv */
`timescale 1ns/100ps

module key_debounce (
    input  logic clk,
    input  logic RSTn,
    input  logic key_in,
    output logic key_out
);

    logic                                            key_q;
    logic [$clog2(periph_pkg::DEBOUNCE_TICKS+1)-1:0] cnt;

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            key_q   <= 1'b0;
            cnt     <= '0;
            key_out <= 1'b0;
        end else begin
            key_q <= key_in;
            if (key_in != key_q) begin
                cnt <= '0;    // Restart on any change
            end else if (cnt != periph_pkg::DEBOUNCE_TICKS) begin
                cnt <= cnt + 1'b1;
                // Input held long enough
                if (cnt == periph_pkg::DEBOUNCE_TICKS - 1) begin
                    key_out <= key_q;
                end
            end
        end
    end

endmodule

/* source/keypad_scan.sv */
`timescale 1ns/100ps

module keypad_scan (
    input  logic                clk,
    input  logic                RSTn,
    input  periph_pkg::col_t    col,
    output periph_pkg::row_t    row,
    output periph_pkg::keypad_t keys
);

    logic [$clog2(periph_pkg::SCAN_TICKS)-1:0] tick;
    logic                                      row_done;
    periph_pkg::scan_row_e                     state;
    periph_pkg::scan_row_e                     state_nxt;

    assign row_done = (tick == periph_pkg::SCAN_TICKS - 1);

    always_comb begin
        case (state)
            periph_pkg::ROW0: state_nxt = periph_pkg::ROW1;
            periph_pkg::ROW1: state_nxt = periph_pkg::ROW2;
            periph_pkg::ROW2: state_nxt = periph_pkg::ROW3;
            default:          state_nxt = periph_pkg::ROW0;
        endcase
    end

    //--------------------------------------------------
    // Row timing and column capture
    //--------------------------------------------------
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            tick  <= '0;
            state <= periph_pkg::ROW0;
            keys  <= '0;
        end else begin
            tick <= tick + 1'b1;    // Wraps at SCAN_TICKS
            if (row_done) begin
                // Pressed key pulls its column low
                keys[int'(state)*periph_pkg::KEYPAD_COLS +: periph_pkg::KEYPAD_COLS] <= ~col;
                state <= state_nxt;
            end
        end
    end

    // Active low, one row at a time
    assign row = ~(periph_pkg::row_t'(1) << state);

endmodule

/* source/apb_led.sv */
`timescale 1ns/100ps

module apb_led (
    input  logic                  clk,
    input  logic                  RSTn,
    input  periph_pkg::apb_req_t  apb_req,
    input  logic                  sel,
    output periph_pkg::apb_data_t rdata,
    output periph_pkg::led_t      led
);

    logic                 wr_en;
    periph_pkg::reg_ofs_t ofs;

    assign ofs   = apb_req.paddr[11:0];
    assign wr_en = sel && apb_req.penable && apb_req.pwrite
                   && (ofs == periph_pkg::LED_DATA);

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            led <= '0;
        end else if (wr_en) begin
            led <= apb_req.pwdata[periph_pkg::LED_W-1:0];    // Low byte only
        end
    end

    assign rdata = (ofs == periph_pkg::LED_DATA) ? periph_pkg::apb_data_t'(led) : '0;

endmodule

/* source/apb_decoder.sv */
`timescale 1ns/100ps

module apb_decoder (
    input  periph_pkg::apb_req_t  apb_req,
    output logic                  sel_led,
    output logic                  sel_key,
    output logic                  sel_timer,
    input  periph_pkg::apb_data_t rdata_led,
    input  periph_pkg::apb_data_t rdata_key,
    input  periph_pkg::apb_data_t rdata_timer,
    output periph_pkg::apb_rsp_t  apb_rsp
);

    periph_pkg::slot_t slot;

    assign slot = apb_req.paddr[15:12];

    // One select per mapped slot
    assign sel_led   = apb_req.psel && (slot == periph_pkg::SLOT_LED);
    assign sel_key   = apb_req.psel && (slot == periph_pkg::SLOT_KEY);
    assign sel_timer = apb_req.psel && (slot == periph_pkg::SLOT_TIMER);

    //--------------------------------------------------
    // Response mux
    //--------------------------------------------------
    always_comb begin
        case (slot)
            periph_pkg::SLOT_LED:   apb_rsp.prdata = rdata_led;
            periph_pkg::SLOT_KEY:   apb_rsp.prdata = rdata_key;
            periph_pkg::SLOT_TIMER: apb_rsp.prdata = rdata_timer;
            default:                apb_rsp.prdata = '0;    // Unmapped, incl. old UART slot
        endcase
    end

    // No wait states and no error responses
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = 1'b0;

endmodule

/* source/periph_pkg.sv */
package periph_pkg;

    // Bus and peripheral widths
    localparam int APB_ADDR_W  = 16;
    localparam int DATA_W      = 32;
    localparam int LED_W       = 8;
    localparam int KEY_N       = 4;
    localparam int KEYPAD_ROWS = 4;
    localparam int KEYPAD_COLS = 4;

    // Timing in clk cycles
    localparam int SCAN_TICKS     = 16;    // Per keypad row
    localparam int DEBOUNCE_TICKS = 32;    // Stable time before key output follows

    //--------------------------------------------------
    // Vector types
    //--------------------------------------------------
    typedef logic [APB_ADDR_W-1:0]               apb_addr_t;
    typedef logic [DATA_W-1:0]                   apb_data_t;
    typedef logic [LED_W-1:0]                    led_t;
    typedef logic [KEY_N-1:0]                    key_vec_t;
    typedef logic [KEYPAD_ROWS*KEYPAD_COLS-1:0]  keypad_t;    // Index is row*4 + col
    typedef logic [KEYPAD_ROWS-1:0]              row_t;
    typedef logic [KEYPAD_COLS-1:0]              col_t;
    typedef logic [3:0]                          slot_t;      // paddr[15:12]
    typedef logic [11:0]                         reg_ofs_t;   // paddr[11:0]

    // Decode slots
    localparam slot_t SLOT_LED   = 4'd1;
    localparam slot_t SLOT_KEY   = 4'd2;
    localparam slot_t SLOT_TIMER = 4'd3;

    // Register offsets
    localparam reg_ofs_t LED_DATA    = 12'h000;
    localparam reg_ofs_t KEY_DATA    = 12'h000;
    localparam reg_ofs_t KEY_INTEN   = 12'h004;
    localparam reg_ofs_t KEY_INTSTAT = 12'h008;
    localparam reg_ofs_t TMR_CTRL    = 12'h000;
    localparam reg_ofs_t TMR_VALUE   = 12'h004;
    localparam reg_ofs_t TMR_RELOAD  = 12'h008;
    localparam reg_ofs_t TMR_INTSTAT = 12'h00C;

    //--------------------------------------------------
    // Bus bundles
    //--------------------------------------------------
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    typedef struct packed {
        key_vec_t key_int;
        logic     timer_int;
    } irq_t;

    // Keypad scan FSM
    typedef enum logic [1:0] {
        ROW0,
        ROW1,
        ROW2,
        ROW3
    } scan_row_e;

endpackage
